//--- common/wrb_pkg.sv
////////////////////////////////////////////////////////////
// Sizes and bus types of the write-response bank
// Every bank module refers to these by scoped names
////////////////////////////////////////////////////////////

`default_nettype none

package wrb_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  // AXI identifiers and their width
  localparam int unsigned NumIds = 4;
  localparam int unsigned IdWidth = 2;

  // Shared slot pool
  localparam int unsigned BankCapa = 16;
  localparam int unsigned BankAddrWidth = 4;

  // Response content without the identifier
  localparam int unsigned MsgWidth = 8;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [IdWidth-1:0] id_t;
  typedef logic [BankAddrWidth-1:0] slot_addr_t;

  // One bit per slot, for release enables, valid bits and freed pulses
  typedef logic [BankCapa-1:0] slot_mask_t;
  typedef logic [NumIds-1:0] id_mask_t;

  // AXI write response without its handshake
  typedef struct packed {
    id_t id;
    logic [MsgWidth-1:0] content;
  } write_resp_t;

  // Accepted reservation, allocator to list control
  typedef struct packed {
    logic valid;
    id_t id;
    slot_addr_t addr;
  } res_grant_t;

  // Release choice, arbiter to the other stages
  typedef struct packed {
    logic valid;
    id_t id;
    slot_addr_t addr;
  } rel_sel_t;

endpackage

`default_nettype wire

//--- source/wrb_slot_alloc.sv
////////////////////////////////////////////////////////////
// Slot allocator of the write-response bank
// Keeps the slot valid bits, hands out the lowest free slot
// and frees the slot picked for release
////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module wrb_slot_alloc (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  i_res_valid,
  input  wire wrb_pkg::id_t          i_res_id,
  input  wire wrb_pkg::rel_sel_t     i_rel,
  output logic                       o_res_ready,
  output wrb_pkg::slot_addr_t        o_res_addr,
  output wrb_pkg::res_grant_t        o_grant,
  output wrb_pkg::slot_mask_t        o_rel_addr_onehot
);

  // One bit per slot that is reserved or filled
  wrb_pkg::slot_mask_t slot_v_q;
  wrb_pkg::slot_mask_t slot_v_d;
  wrb_pkg::slot_mask_t grant_mask;
  wrb_pkg::slot_mask_t rel_mask;
  wrb_pkg::slot_addr_t free_addr;

  // Lowest free slot by a scan from the top where the last hit wins
  always_comb begin : find_free
    free_addr = '0;
    for (int i = wrb_pkg::BankCapa - 1; i >= 0; i--) begin
      if (!slot_v_q[i]) begin
        free_addr = i[wrb_pkg::BankAddrWidth-1:0];
      end
    end
  end : find_free

  // Ready while any slot is left
  assign o_res_ready = ~&slot_v_q;
  assign o_res_addr  = free_addr;

  assign o_grant.valid = i_res_valid && o_res_ready;
  assign o_grant.id    = i_res_id;
  assign o_grant.addr  = free_addr;

  // Set and clear masks for two slots that never coincide
  assign grant_mask = o_grant.valid ? wrb_pkg::slot_mask_t'(1) << free_addr : '0;
  assign rel_mask   = i_rel.valid ? wrb_pkg::slot_mask_t'(1) << i_rel.addr : '0;

  assign slot_v_d = (slot_v_q | grant_mask) & ~rel_mask;

  // Freed slot pulses during the selection cycle only
  assign o_rel_addr_onehot = rel_mask;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_v_q <= '0;
    end else begin
      slot_v_q <= slot_v_d;
    end
  end

  // The granted slot was free, so a full pool grants nothing
  grant_slot_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    o_grant.valid |-> !slot_v_q[o_grant.addr]);

  // Only a slot in use can be released
  rel_slot_used: assert property (@(posedge clk_i) disable iff (!rst_ni)
    i_rel.valid |-> slot_v_q[i_rel.addr]);

endmodule

`default_nettype wire

//--- wrb_lists/wrb_list_ctrl.sv
////////////////////////////////////////////////////////////
// Per-identifier linked lists over the shared slot pool
// Tracks head, fill and tail pointers with their counts and
// steers message writes to the oldest unfilled slot
////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module wrb_list_ctrl (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire wrb_pkg::res_grant_t   i_grant,
  input  wire logic                  i_in_valid,
  input  wire wrb_pkg::write_resp_t  i_in_data,
  input  wire wrb_pkg::rel_sel_t     i_rel,
  output logic                       o_in_ready,
  output logic                       o_wr_en,
  output wrb_pkg::slot_addr_t        o_wr_addr,
  output wrb_pkg::slot_addr_t [wrb_pkg::NumIds-1:0] o_oldest,
  output wrb_pkg::id_mask_t          o_has_filled
);

  // Counts reach the full pool and need one extra bit
  typedef logic [wrb_pkg::BankAddrWidth:0] cnt_t;

  ////////////////////////////////////////////////////////////
  // Pointers and counts
  ////////////////////////////////////////////////////////////

  // Head is the last reserved slot and tail the oldest one
  wrb_pkg::slot_addr_t head_q [wrb_pkg::NumIds];
  wrb_pkg::slot_addr_t head_d [wrb_pkg::NumIds];
  // Fill is the oldest reserved slot still waiting for data
  wrb_pkg::slot_addr_t fill_q [wrb_pkg::NumIds];
  wrb_pkg::slot_addr_t fill_d [wrb_pkg::NumIds];
  wrb_pkg::slot_addr_t tail_q [wrb_pkg::NumIds];
  wrb_pkg::slot_addr_t tail_d [wrb_pkg::NumIds];

  // Counts of reserved unfilled and of filled unreleased slots
  cnt_t res_cnt_q  [wrb_pkg::NumIds];
  cnt_t res_cnt_d  [wrb_pkg::NumIds];
  cnt_t fill_cnt_q [wrb_pkg::NumIds];
  cnt_t fill_cnt_d [wrb_pkg::NumIds];

  // Next slot of each slot in its list
  wrb_pkg::slot_addr_t link_q [wrb_pkg::BankCapa];

  wrb_pkg::id_mask_t res_hit;
  wrb_pkg::id_mask_t in_hit;
  wrb_pkg::id_mask_t pop_hit;
  wrb_pkg::id_mask_t empty_after_pop;
  logic in_acc;
  logic link_wr_en;

  // Input needs an unfilled reserved slot of its own identifier
  assign o_in_ready = res_cnt_q[i_in_data.id] != '0;
  assign in_acc     = i_in_valid && o_in_ready;

  // Data goes to the fill slot of the incoming identifier
  assign o_wr_en   = in_acc;
  assign o_wr_addr = fill_q[i_in_data.id];

  always_comb begin : list_next
    for (int i = 0; i < wrb_pkg::NumIds; i++) begin
      res_hit[i] = i_grant.valid && (i_grant.id == i);
      in_hit[i]  = in_acc && (i_in_data.id == i);
      pop_hit[i] = i_rel.valid && (i_rel.id == i);
      // A pop only ever takes a filled slot
      empty_after_pop[i] = (res_cnt_q[i] == '0) && (fill_cnt_q[i] == cnt_t'(pop_hit[i]));

      head_d[i] = head_q[i];
      fill_d[i] = fill_q[i];
      tail_d[i] = tail_q[i];

      if (res_hit[i] && empty_after_pop[i]) begin
        // Fresh list with all pointers on the new slot
        head_d[i] = i_grant.addr;
        fill_d[i] = i_grant.addr;
        tail_d[i] = i_grant.addr;
      end else begin
        if (res_hit[i]) begin
          head_d[i] = i_grant.addr;
        end
        // No unfilled slot left after this input, so fill jumps to the new one
        if (res_hit[i] && (res_cnt_q[i] == cnt_t'(in_hit[i]))) begin
          fill_d[i] = i_grant.addr;
        end else if (in_hit[i]) begin
          fill_d[i] = link_q[fill_q[i]];
        end
        if (pop_hit[i]) begin
          tail_d[i] = link_q[tail_q[i]];
        end
      end

      res_cnt_d[i]  = res_cnt_q[i] + cnt_t'(res_hit[i]) - cnt_t'(in_hit[i]);
      fill_cnt_d[i] = fill_cnt_q[i] + cnt_t'(in_hit[i]) - cnt_t'(pop_hit[i]);

      o_oldest[i]     = tail_q[i];
      o_has_filled[i] = fill_cnt_q[i] != '0;
    end
  end : list_next

  // Chain the new slot behind the current head
  assign link_wr_en = i_grant.valid && !empty_after_pop[i_grant.id];

  always_ff @(posedge clk_i) begin
    if (link_wr_en) begin
      link_q[head_q[i_grant.id]] <= i_grant.addr;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < wrb_pkg::NumIds; i++) begin
        head_q[i]     <= '0;
        fill_q[i]     <= '0;
        tail_q[i]     <= '0;
        res_cnt_q[i]  <= '0;
        fill_cnt_q[i] <= '0;
      end
    end else begin
      head_q     <= head_d;
      fill_q     <= fill_d;
      tail_q     <= tail_d;
      res_cnt_q  <= res_cnt_d;
      fill_cnt_q <= fill_cnt_d;
    end
  end

  // Input to a single unfilled slot lands on the newest reservation
  fill_at_head: assert property (@(posedge clk_i) disable iff (!rst_ni)
    o_wr_en && (res_cnt_q[i_in_data.id] == cnt_t'(1))
    |-> o_wr_addr == head_q[i_in_data.id]);

  // Arbiter pops only lists holding a filled entry
  pop_has_fill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    i_rel.valid |-> fill_cnt_q[i_rel.id] != '0);

endmodule

`default_nettype wire

//--- source/wrb_release_arb.sv
////////////////////////////////////////////////////////////
// Release arbiter of the write-response bank
// Picks the lowest identifier whose oldest slot is filled
// and release-enabled, while the output stage is empty
////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module wrb_release_arb (
  input  wire wrb_pkg::slot_mask_t   i_release_en,
  input  wire wrb_pkg::slot_addr_t [wrb_pkg::NumIds-1:0] i_oldest,
  input  wire wrb_pkg::id_mask_t     i_has_filled,
  input  wire logic                  i_out_empty,
  output wrb_pkg::rel_sel_t          o_rel
);

  // Identifiers that could release this cycle
  wrb_pkg::id_mask_t cand;
  wrb_pkg::id_t      sel_id;

  always_comb begin : cand_gen
    for (int i = 0; i < wrb_pkg::NumIds; i++) begin
      cand[i] = i_has_filled[i] && i_release_en[i_oldest[i]];
    end
  end : cand_gen

  // Lowest candidate wins by a scan from the top
  always_comb begin : pick_lowest
    sel_id = '0;
    for (int i = wrb_pkg::NumIds - 1; i >= 0; i--) begin
      if (cand[i]) begin
        sel_id = i[wrb_pkg::IdWidth-1:0];
      end
    end
  end : pick_lowest

  // Nothing goes out while the output register is busy
  assign o_rel.valid = i_out_empty && |cand;
  assign o_rel.id    = sel_id;
  assign o_rel.addr  = i_oldest[sel_id];

endmodule

`default_nettype wire

//--- source/wrb_out_stage.sv
////////////////////////////////////////////////////////////
// Message RAM and output register of the bank
// Loads on a release choice, empties on a taken output
////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module wrb_out_stage (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  wire logic                          i_wr_en,
  input  wire wrb_pkg::slot_addr_t           i_wr_addr,
  input  wire logic [wrb_pkg::MsgWidth-1:0]  i_wr_content,
  input  wire wrb_pkg::rel_sel_t             i_rel,
  input  wire logic                          i_out_ready,
  output logic                               o_out_empty,
  output logic                               o_out_valid,
  output wrb_pkg::write_resp_t               o_out_data
);

  ////////////////////////////////////////////////////////////
  // Message RAM
  ////////////////////////////////////////////////////////////

  // Content only, the identifier comes with the release choice
  logic [wrb_pkg::MsgWidth-1:0] msg_ram [wrb_pkg::BankCapa];

  always_ff @(posedge clk_i) begin
    if (i_wr_en) begin
      msg_ram[i_wr_addr] <= i_wr_content;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  logic out_valid_q;
  wrb_pkg::write_resp_t out_data_q;

  // Arbiter only selects when empty, so load and drain never overlap
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (i_rel.valid) begin
      out_valid_q <= 1'b1;
    end else if (out_valid_q && i_out_ready) begin
      out_valid_q <= 1'b0;
    end
  end

  // Read of the selected slot, same edge as its release
  always_ff @(posedge clk_i) begin
    if (i_rel.valid) begin
      out_data_q.id      <= i_rel.id;
      out_data_q.content <= msg_ram[i_rel.addr];
    end
  end

  assign o_out_empty = !out_valid_q;
  assign o_out_valid = out_valid_q;
  assign o_out_data  = out_data_q;

  // Held response stays put until taken
  out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out_data));

endmodule

`default_nettype wire

//--- source/wrb_top.sv
////////////////////////////////////////////////////////////
// Top of the write-response bank
// Reservation, fill, release selection and output in a row
////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module wrb_top (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  i_res_valid,
  input  wire wrb_pkg::id_t          i_res_id,
  output logic                       o_res_ready,
  output wrb_pkg::slot_addr_t        o_res_addr,
  input  wire logic                  i_in_valid,
  input  wire wrb_pkg::write_resp_t  i_in_data,
  output logic                       o_in_ready,
  input  wire wrb_pkg::slot_mask_t   i_release_en,
  output wrb_pkg::slot_mask_t        o_rel_addr_onehot,
  output logic                       o_out_valid,
  output wrb_pkg::write_resp_t       o_out_data,
  input  wire logic                  i_out_ready
);

  wrb_pkg::res_grant_t grant;
  wrb_pkg::rel_sel_t   rel;
  logic                wr_en;
  wrb_pkg::slot_addr_t wr_addr;
  wrb_pkg::slot_addr_t [wrb_pkg::NumIds-1:0] oldest;
  wrb_pkg::id_mask_t   has_filled;
  logic                out_empty;

  // Reservation
  wrb_slot_alloc u_slot_alloc (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .i_res_valid       (i_res_valid),
    .i_res_id          (i_res_id),
    .i_rel             (rel),
    .o_res_ready       (o_res_ready),
    .o_res_addr        (o_res_addr),
    .o_grant           (grant),
    .o_rel_addr_onehot (o_rel_addr_onehot)
  );

  // Fill and list upkeep
  wrb_list_ctrl u_list_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .i_grant      (grant),
    .i_in_valid   (i_in_valid),
    .i_in_data    (i_in_data),
    .i_rel        (rel),
    .o_in_ready   (o_in_ready),
    .o_wr_en      (wr_en),
    .o_wr_addr    (wr_addr),
    .o_oldest     (oldest),
    .o_has_filled (has_filled)
  );

  // Release selection
  wrb_release_arb u_release_arb (
    .i_release_en (i_release_en),
    .i_oldest     (oldest),
    .i_has_filled (has_filled),
    .i_out_empty  (out_empty),
    .o_rel        (rel)
  );

  // Output
  wrb_out_stage u_out_stage (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .i_wr_en      (wr_en),
    .i_wr_addr    (wr_addr),
    .i_wr_content (i_in_data.content),
    .i_rel        (rel),
    .i_out_ready  (i_out_ready),
    .o_out_empty  (out_empty),
    .o_out_valid  (o_out_valid),
    .o_out_data   (o_out_data)
  );

endmodule

`default_nettype wire

//--- bench/wrb_tb.sv
////////////////////////////////////////////////////////////
// Testbench of the write-response bank
// Random reservations, inputs, release enables and output
// back-pressure, checked cycle by cycle against a model
////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module wrb_tb;

  // Stimulus length and the watchdog limit derived from it
  localparam int unsigned NumCycles     = 2000;
  localparam int unsigned TimeoutCycles = NumCycles + NumCycles / 2;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 i_res_valid;
  wrb_pkg::id_t         i_res_id;
  logic                 o_res_ready;
  wrb_pkg::slot_addr_t  o_res_addr;
  logic                 i_in_valid;
  wrb_pkg::write_resp_t i_in_data;
  logic                 o_in_ready;
  wrb_pkg::slot_mask_t  i_release_en;
  wrb_pkg::slot_mask_t  o_rel_addr_onehot;
  logic                 o_out_valid;
  wrb_pkg::write_resp_t o_out_data;
  logic                 i_out_ready;

  ////////////////////////////////////////////////////////////
  // Reference model state
  ////////////////////////////////////////////////////////////

  // Slots in use, and per identifier a queue with its oldest entry at index 0
  wrb_pkg::slot_mask_t          used;
  wrb_pkg::slot_addr_t          ent_slot    [wrb_pkg::NumIds][wrb_pkg::BankCapa];
  logic                         ent_filled  [wrb_pkg::NumIds][wrb_pkg::BankCapa];
  logic [wrb_pkg::MsgWidth-1:0] ent_content [wrb_pkg::NumIds][wrb_pkg::BankCapa];
  int                           ent_cnt     [wrb_pkg::NumIds];
  // Output register as the model sees it
  logic                         out_busy;
  wrb_pkg::write_resp_t         out_exp;
  int                           err_cnt;
  int                           cycle_cnt;
  int                           seed;

  wrb_top UUT (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .i_res_valid       (i_res_valid),
    .i_res_id          (i_res_id),
    .o_res_ready       (o_res_ready),
    .o_res_addr        (o_res_addr),
    .i_in_valid        (i_in_valid),
    .i_in_data         (i_in_data),
    .o_in_ready        (o_in_ready),
    .i_release_en      (i_release_en),
    .o_rel_addr_onehot (o_rel_addr_onehot),
    .o_out_valid       (o_out_valid),
    .o_out_data        (o_out_data),
    .i_out_ready       (i_out_ready)
  );

  // 100 ns clock
  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Failure and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic fail_run();
    err_cnt++;
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_resp(input string name, input wrb_pkg::write_resp_t got,
                            input wrb_pkg::write_resp_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_addr(input string name, input wrb_pkg::slot_addr_t got,
                            input wrb_pkg::slot_addr_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_mask(input string name, input wrb_pkg::slot_mask_t got,
                            input wrb_pkg::slot_mask_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Model queries
  ////////////////////////////////////////////////////////////

  // Lowest unused slot, or -1 with a full pool
  function automatic int lowest_free();
    int found;
    found = -1;
    for (int i = 0; i < wrb_pkg::BankCapa; i++) begin
      if (!used[i] && found < 0) begin
        found = i;
      end
    end
    return found;
  endfunction

  function automatic logic has_unfilled(input wrb_pkg::id_t id);
    logic hit;
    hit = 1'b0;
    for (int k = 0; k < ent_cnt[id]; k++) begin
      if (!ent_filled[id][k]) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // Lowest identifier whose oldest entry is filled and enabled, or -1
  function automatic int release_choice(input wrb_pkg::slot_mask_t en);
    int found;
    found = -1;
    for (int id = 0; id < wrb_pkg::NumIds; id++) begin
      if (found < 0 && ent_cnt[id] > 0 && ent_filled[id][0] && en[ent_slot[id][0]]) begin
        found = id;
      end
    end
    return found;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus, checks and model update
  ////////////////////////////////////////////////////////////

  task automatic drive_inputs();
    wrb_pkg::id_t id;
    id                = wrb_pkg::id_t'($urandom);
    i_res_valid       = ($urandom % 5) < 2;
    i_res_id          = wrb_pkg::id_t'($urandom);
    i_in_data.id      = id;
    i_in_data.content = 8'($urandom);
    // Input only towards identifiers with a reserved, unfilled entry
    i_in_valid        = has_unfilled(id) && (($urandom % 4) != 0);
    i_release_en      = wrb_pkg::slot_mask_t'($urandom);
    i_out_ready       = $urandom % 2;
  endtask

  // Called mid-cycle, while inputs and outputs are settled
  task automatic check_and_advance();
    int                  free_slot;
    int                  sel;
    int                  k;
    logic                in_rdy_exp;
    wrb_pkg::id_t        in_id;
    wrb_pkg::slot_mask_t mask_exp;
    free_slot  = lowest_free();
    in_id      = i_in_data.id;
    in_rdy_exp = has_unfilled(in_id);
    // No selection while the output register holds a response
    sel        = out_busy ? -1 : release_choice(i_release_en);
    mask_exp   = '0;
    if (sel >= 0) begin
      mask_exp[ent_slot[sel][0]] = 1'b1;
    end

    check_flag("o_res_ready", o_res_ready, free_slot >= 0);
    if (free_slot >= 0) begin
      check_addr("o_res_addr", o_res_addr, wrb_pkg::slot_addr_t'(free_slot));
    end
    check_flag("o_in_ready", o_in_ready, in_rdy_exp);
    check_mask("o_rel_addr_onehot", o_rel_addr_onehot, mask_exp);
    check_flag("o_out_valid", o_out_valid, out_busy);
    if (out_busy) begin
      check_resp("o_out_data", o_out_data, out_exp);
    end

    // Input fills the oldest unfilled entry
    if (i_in_valid && in_rdy_exp) begin
      k = 0;
      while (k < ent_cnt[in_id] && ent_filled[in_id][k]) begin
        k++;
      end
      ent_filled[in_id][k]  = 1'b1;
      ent_content[in_id][k] = i_in_data.content;
    end
    // New reservation goes to the back of its queue
    if (i_res_valid && free_slot >= 0) begin
      used[free_slot] = 1'b1;
      ent_slot[i_res_id][ent_cnt[i_res_id]]   = wrb_pkg::slot_addr_t'(free_slot);
      ent_filled[i_res_id][ent_cnt[i_res_id]] = 1'b0;
      ent_cnt[i_res_id]++;
    end
    // Selection pops the queue and frees the slot at once
    if (sel >= 0) begin
      used[ent_slot[sel][0]] = 1'b0;
      out_exp.id      = wrb_pkg::id_t'(sel);
      out_exp.content = ent_content[sel][0];
      for (k = 0; k < ent_cnt[sel] - 1; k++) begin
        ent_slot[sel][k]    = ent_slot[sel][k+1];
        ent_filled[sel][k]  = ent_filled[sel][k+1];
        ent_content[sel][k] = ent_content[sel][k+1];
      end
      ent_cnt[sel]--;
      out_busy = 1'b1;
    end else if (out_busy && i_out_ready) begin
      out_busy = 1'b0;
    end
  endtask

  // Watchdog
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the run did not end within %0d cycles", TimeoutCycles);
      fail_run();
    end
  end

  initial begin
    seed = 58;
    void'($urandom(seed));
    err_cnt   = 0;
    cycle_cnt = 0;
    used      = '0;
    out_busy  = 1'b0;
    out_exp   = '0;
    for (int id = 0; id < wrb_pkg::NumIds; id++) begin
      ent_cnt[id] = 0;
    end
    rst_ni       = 1'b0;
    i_res_valid  = 1'b0;
    i_res_id     = '0;
    i_in_valid   = 1'b0;
    i_in_data    = '0;
    i_release_en = '0;
    i_out_ready  = 1'b0;

    // Reset for 3 cycles
    repeat (3) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(negedge clk_i);
    // Idle state right after reset
    check_flag("o_out_valid", o_out_valid, 1'b0);
    check_flag("o_in_ready", o_in_ready, 1'b0);
    check_mask("o_rel_addr_onehot", o_rel_addr_onehot, '0);
    check_flag("o_res_ready", o_res_ready, 1'b1);

    repeat (NumCycles) begin
      @(posedge clk_i);
      #10;
      drive_inputs();
      @(negedge clk_i);
      check_and_advance();
    end

    if (err_cnt == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      fail_run();
    end
  end

endmodule

`default_nettype wire

//--- list.f
common/wrb_pkg.sv
source/wrb_slot_alloc.sv
wrb_lists/wrb_list_ctrl.sv
source/wrb_release_arb.sv
source/wrb_out_stage.sv
source/wrb_top.sv
bench/wrb_tb.sv

//--- Bender.yml
package:
  name: wrb

sources:
  # Package first, then the RTL in dependency order
  - files:
      - common/wrb_pkg.sv
      - source/wrb_slot_alloc.sv
      - wrb_lists/wrb_list_ctrl.sv
      - source/wrb_release_arb.sv
      - source/wrb_out_stage.sv
      - source/wrb_top.sv

  # Testbench
  - target: test
    files:
      - bench/wrb_tb.sv
